// ==== rtl/sa_operand_if.sv ====
`timescale 1ns/10ps

interface sa_operand_if #(
    parameter int rows = 4,
    parameter int cols = 4
);
    import sa_pkg::*;

    sa_mode_e                          mode;
    // one valid per column, entering the top row of the grid
    logic [cols-1:0]                   valid;
    // weight bytes entering column 0, one per row
    logic [rows-1:0][weight_w-1:0]     weights;
    // pixel words entering row 0, one per column
    logic [cols-1:0][column_in_w-1:0]  pixels;

    modport source (
        output mode, valid, weights, pixels
    );

    modport sink (
        input mode, valid, weights, pixels
    );

endinterface

// ==== rtl/sa_operand_skew.sv ====
`timescale 1ns/10ps

module sa_operand_skew #(
    parameter int rows = 4,
    parameter int cols = 4
) (
    input  logic                                  clk,
    input  logic                                  channel_out_reset,
    input  logic                                  en,
    input  sa_pkg::sa_mode_e                      mode,
    input  logic [rows*sa_pkg::weight_w-1:0]      row_in,
    input  logic [cols*sa_pkg::column_in_w-1:0]   column_in,
    sa_operand_if.source                          ops
);
    import sa_pkg::*;

    logic [rows-1:0][weight_w-1:0]     weight_q;
    logic [cols-1:0][column_in_w-1:0]  pixel_q;
    logic                              valid_q;

    wire  [rows-1:0][weight_w-1:0]     weight_skew;
    wire  [cols-1:0][column_in_w-1:0]  pixel_skew;
    wire  [cols-1:0]                   valid_skew;

    // beat register, payload only loads on en
    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            weight_q <= '0;
            pixel_q  <= '0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= en;
            if (en) begin
                weight_q <= row_in;
                pixel_q  <= column_in;
            end
        end
    end

    ////////////////////
    // row i weights, i cycles late
    ////////////////////
    for (genvar i = 0; i < rows; i++) begin : g_wrow
        if (i == 0) begin : g_direct
            assign weight_skew[i] = weight_q[i];
        end else begin : g_delay
            logic [i-1:0][weight_w-1:0] dly;

            always_ff @(posedge clk) begin
                if (channel_out_reset) begin
                    dly <= '0;
                end else begin
                    dly <= (i*weight_w)'({dly, weight_q[i]});
                end
            end

            assign weight_skew[i] = dly[i-1];
        end
    end

    ////////////////////
    // column j pixels + valid, j cycles late
    ////////////////////
    for (genvar j = 0; j < cols; j++) begin : g_pcol
        if (j == 0) begin : g_direct
            assign {valid_skew[j], pixel_skew[j]} = {valid_q, pixel_q[j]};
        end else begin : g_delay
            logic [j-1:0][column_in_w:0] dly;

            always_ff @(posedge clk) begin
                if (channel_out_reset) begin
                    dly <= '0;
                end else begin
                    dly <= (j*(column_in_w+1))'({dly, valid_q, pixel_q[j]});
                end
            end

            assign {valid_skew[j], pixel_skew[j]} = dly[j-1];
        end
    end

    assign ops.mode    = mode;
    assign ops.weights = weight_skew;
    assign ops.pixels  = pixel_skew;
    assign ops.valid   = valid_skew;

endmodule

// ==== rtl/sa_pe.sv ====
`timescale 1ns/10ps

module sa_pe (
    input  logic                            clk,
    input  logic                            channel_out_reset,
    input  sa_pkg::sa_mode_e                mode,
    input  logic                            valid_in,
    input  logic [sa_pkg::weight_w-1:0]     weight_in,
    input  logic [sa_pkg::column_in_w-1:0]  pixel_in,
    output logic                            valid_out,
    output logic [sa_pkg::weight_w-1:0]     weight_out,
    output logic [sa_pkg::column_in_w-1:0]  pixel_out,
    output logic [sa_pkg::pe_out_w-1:0]     result
);
    import sa_pkg::*;

    // two 1-bit weights per pixel in mode 18
    localparam int lanes_18 = 2 * pixel_lanes;

    logic signed [acc_w_88-1:0]  prod_88 [pixel_lanes];
    logic [acc_w_18-1:0]         term_18 [lanes_18];
    logic [pe_out_w-1:0]         acc;
    logic [pe_out_w-1:0]         acc_next;

    // operand registers double as the forwarding path
    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            valid_out  <= 1'b0;
            weight_out <= '0;
            pixel_out  <= '0;
        end else begin
            valid_out  <= valid_in;
            weight_out <= weight_in;
            pixel_out  <= pixel_in;
        end
    end

    // signed weight x unsigned pixel
    always_comb begin
        for (int p = 0; p < pixel_lanes; p++) begin
            prod_88[p] = $signed(weight_out) * $signed({1'b0, pixel_out[p*pixel_w +: pixel_w]});
        end
    end

    // bit clear adds the pixel, bit set subtracts it
    always_comb begin
        logic [acc_w_18-1:0] pix;
        for (int k = 0; k < 2; k++) begin
            for (int p = 0; p < pixel_lanes; p++) begin
                pix = {{(acc_w_18-pixel_w){1'b0}}, pixel_out[p*pixel_w +: pixel_w]};
                term_18[k*pixel_lanes + p] = weight_out[k] ? -pix : pix;
            end
        end
    end

    // lanes wrap at their own width
    always_comb begin
        acc_next = acc;
        if (mode == mode_88) begin
            for (int p = 0; p < pixel_lanes; p++) begin
                acc_next[p*acc_w_88 +: acc_w_88] = acc[p*acc_w_88 +: acc_w_88] + prod_88[p];
            end
        end else begin
            for (int l = 0; l < lanes_18; l++) begin
                acc_next[l*acc_w_18 +: acc_w_18] = acc[l*acc_w_18 +: acc_w_18] + term_18[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            acc <= '0;
        end else if (valid_out) begin
            acc <= acc_next;
        end
    end

    assign result = acc;

endmodule

// ==== rtl/sa_pe_array.sv ====
`timescale 1ns/10ps

module sa_pe_array #(
    parameter int rows = 4,
    parameter int cols = 4
) (
    input  logic                                     clk,
    input  logic                                     channel_out_reset,
    sa_operand_if.sink                               ops,
    output logic [rows*cols*sa_pkg::pe_out_w-1:0]    results
);
    import sa_pkg::*;

    // horizontal weight links, column cols is the unused east edge
    logic [weight_w-1:0]     weight_h [rows][cols+1];
    // vertical pixel and valid links, row rows is the south edge
    logic [column_in_w-1:0]  pixel_v  [rows+1][cols];
    logic                    valid_v  [rows+1][cols];

    ////////////////////
    // grid edges
    ////////////////////
    for (genvar i = 0; i < rows; i++) begin : g_west
        assign weight_h[i][0] = ops.weights[i];
    end

    for (genvar j = 0; j < cols; j++) begin : g_north
        assign pixel_v[0][j] = ops.pixels[j];
        assign valid_v[0][j] = ops.valid[j];
    end

    ////////////////////
    // mesh
    ////////////////////
    for (genvar i = 0; i < rows; i++) begin : g_row
        for (genvar j = 0; j < cols; j++) begin : g_col
            sa_pe u_pe (
                .clk               (clk),
                .channel_out_reset (channel_out_reset),
                .mode              (ops.mode),
                .valid_in          (valid_v[i][j]),
                .weight_in         (weight_h[i][j]),
                .pixel_in          (pixel_v[i][j]),
                .valid_out         (valid_v[i+1][j]),
                .weight_out        (weight_h[i][j+1]),
                .pixel_out         (pixel_v[i+1][j]),
                .result            (results[(i*cols + j)*pe_out_w +: pe_out_w])
            );
        end
    end

endmodule

// ==== rtl/sa_pkg.sv ====
package sa_pkg;

    ////////////////////
    // operand widths
    ////////////////////

    // one signed weight byte per row input
    localparam int weight_w = 8;

    // unsigned pixels packed into each column input
    localparam int pixel_w     = 8;
    localparam int pixel_lanes = 2;
    localparam int column_in_w = pixel_w * pixel_lanes;

    ////////////////////
    // accumulators
    ////////////////////

    // mode 88 keeps two wide lanes, mode 18 four narrow ones
    localparam int acc_w_88 = 24;
    localparam int acc_w_18 = 16;

    // packed pe result, sized for the four mode 18 lanes
    localparam int pe_out_w = 64;

    // 88: signed 8b weight x two pixels
    // 18: two 1-bit weights (+1 / -1) x two pixels
    typedef enum logic {
        mode_88 = 1'b0,
        mode_18 = 1'b1
    } sa_mode_e;

endpackage

// ==== rtl/sa_row_readout.sv ====
`timescale 1ns/10ps

module sa_row_readout #(
    parameter int rows = 4,
    parameter int cols = 4
) (
    input  logic                                     clk,
    input  logic                                     channel_out_reset,
    input  logic                                     channel_out_en,
    input  sa_pkg::sa_mode_e                         mode,
    input  logic [rows*cols*sa_pkg::pe_out_w-1:0]    results,
    output logic [cols*sa_pkg::pe_out_w-1:0]         out
);
    import sa_pkg::*;

    localparam int cnt_w   = (rows > 1) ? $clog2(rows) : 1;
    localparam int row_w   = cols * pe_out_w;
    localparam int half_88 = pixel_lanes * acc_w_88;
    localparam int half_18 = pixel_lanes * acc_w_18;

    logic [cnt_w-1:0]     row_cnt;
    logic [row_w-1:0]     row_sel;
    logic [row_w-1:0]     packed_row;
    logic [pe_out_w-1:0]  pe_res;

    // one row per enabled cycle, wraps at rows-1
    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            row_cnt <= '0;
        end else if (channel_out_en) begin
            if (row_cnt == cnt_w'(rows - 1)) begin
                row_cnt <= '0;
            end else begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    assign row_sel = results[row_cnt*row_w +: row_w];

    // 88: two 24b lanes per column, low end
    // 18: w0 lanes low half, w1 lanes high half
    always_comb begin
        packed_row = '0;
        pe_res     = '0;
        for (int j = 0; j < cols; j++) begin
            pe_res = row_sel[j*pe_out_w +: pe_out_w];
            if (mode == mode_88) begin
                packed_row[j*half_88 +: half_88] = pe_res[half_88-1:0];
            end else begin
                packed_row[j*half_18 +: half_18] = pe_res[half_18-1:0];
                packed_row[cols*half_18 + j*half_18 +: half_18] = pe_res[2*half_18-1:half_18];
            end
        end
    end

    assign out = channel_out_en ? packed_row : '0;

endmodule

// ==== rtl/sa_top.sv ====
`timescale 1ns/10ps

module sa_top #(
    parameter int rows = 4,
    parameter int cols = 4
) (
    input  logic                                  clk,
    input  logic                                  channel_out_reset,
    input  logic                                  en,
    input  sa_pkg::sa_mode_e                      mode,
    input  logic [rows*sa_pkg::weight_w-1:0]      row_in,
    input  logic [cols*sa_pkg::column_in_w-1:0]   column_in,
    input  logic                                  channel_out_en,
    output logic [cols*sa_pkg::pe_out_w-1:0]      out
);
    import sa_pkg::*;

    logic [rows*cols*pe_out_w-1:0] results;

    sa_operand_if #(.rows(rows), .cols(cols)) ops ();

    // input side, skews operands into the grid
    sa_operand_skew #(.rows(rows), .cols(cols)) u_skew (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .en                (en),
        .mode              (mode),
        .row_in            (row_in),
        .column_in         (column_in),
        .ops               (ops.source)
    );

    sa_pe_array #(.rows(rows), .cols(cols)) u_array (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .ops               (ops.sink),
        .results           (results)
    );

    // output side, one array row per enabled cycle
    sa_row_readout #(.rows(rows), .cols(cols)) u_readout (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .channel_out_en    (channel_out_en),
        .mode              (mode),
        .results           (results),
        .out               (out)
    );

endmodule

// ==== testbench/sa_tb.sv ====
`timescale 1ns/10ps

module sa_tb;
    import sa_pkg::*;

    localparam int rows        = 4;
    localparam int cols        = 4;
    localparam int out_w       = cols * pe_out_w;
    localparam int num_tests   = 6;
    localparam int cycle_limit = num_tests * 60 + 40;

    logic                          clk;
    logic                          channel_out_reset;
    logic                          en;
    sa_mode_e                      mode;
    logic [rows*weight_w-1:0]      row_in;
    logic [cols*column_in_w-1:0]   column_in;
    logic                          channel_out_en;
    logic [out_w-1:0]              out;

    // per-PE reference accumulators, packed like the PE result
    logic [pe_out_w-1:0]  model_acc [rows][cols];
    logic [out_w-1:0]     captured  [rows];
    int                   exp_row;
    int                   errors;
    int                   checks;
    int                   cycles;

    sa_top #(.rows(rows), .cols(cols)) dut0 (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .en                (en),
        .mode              (mode),
        .row_in            (row_in),
        .column_in         (column_in),
        .channel_out_en    (channel_out_en),
        .out               (out)
    );

    bind sa_row_readout sa_tb_assertions #(.rows(rows), .cols(cols), .cnt_w(cnt_w)) u_assert (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .channel_out_en    (channel_out_en),
        .row_cnt           (row_cnt),
        .out               (out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("STATUS: FAIL");
        $finish;
    end

    ////////////////////
    // reference model
    ////////////////////

    function automatic void model_beat(input logic [rows*weight_w-1:0] w,
                                       input logic [cols*column_in_w-1:0] c);
        logic [7:0] wb;
        logic [7:0] pix;
        int         wv;
        int         pv;
        int         term;
        for (int i = 0; i < rows; i++) begin
            wb = w[i*weight_w +: weight_w];
            wv = $signed(wb);
            for (int j = 0; j < cols; j++) begin
                for (int p = 0; p < pixel_lanes; p++) begin
                    pix = c[j*column_in_w + p*pixel_w +: pixel_w];
                    pv  = pix;
                    if (mode == mode_88) begin
                        model_acc[i][j][p*24 +: 24] = model_acc[i][j][p*24 +: 24] + 24'(wv * pv);
                    end else begin
                        // weight bit k set means -1
                        for (int k = 0; k < 2; k++) begin
                            term = wb[k] ? -pv : pv;
                            model_acc[i][j][(k*2+p)*16 +: 16] =
                                model_acc[i][j][(k*2+p)*16 +: 16] + 16'(term);
                        end
                    end
                end
            end
        end
    endfunction

    function automatic logic [out_w-1:0] expected_row(input int r);
        logic [out_w-1:0] row;
        row = '0;
        for (int j = 0; j < cols; j++) begin
            if (mode == mode_88) begin
                row[j*48 +: 48] = model_acc[r][j][47:0];
            end else begin
                row[j*32 +: 32]           = model_acc[r][j][31:0];
                row[cols*32 + j*32 +: 32] = model_acc[r][j][63:32];
            end
        end
        return row;
    endfunction

    ////////////////////
    // drivers and checks
    ////////////////////

    task automatic apply_reset(input sa_mode_e m);
        @(posedge clk);
        #2;
        channel_out_reset = 1'b1;
        en                = 1'b0;
        channel_out_en    = 1'b0;
        mode              = m;
        repeat (2) @(posedge clk);
        #2;
        channel_out_reset = 1'b0;
        for (int i = 0; i < rows; i++) begin
            for (int j = 0; j < cols; j++) begin
                model_acc[i][j] = '0;
            end
        end
        exp_row = 0;
    endtask

    task automatic drive_beat(input logic [rows*weight_w-1:0] w,
                              input logic [cols*column_in_w-1:0] c);
        @(posedge clk);
        #2;
        en        = 1'b1;
        row_in    = w;
        column_in = c;
        model_beat(w, c);
    endtask

    // en low with junk operands on the bus
    task automatic skip_beat();
        @(posedge clk);
        #2;
        en        = 1'b0;
        row_in    = $urandom;
        column_in = {$urandom, $urandom};
    endtask

    task automatic finish_beats();
        @(posedge clk);
        #2;
        en = 1'b0;
        // last beat sampled above, let it cross the whole grid
        repeat (rows + cols + 2) @(posedge clk);
    endtask

    task automatic check_value(input string name, input logic [out_w-1:0] expected,
                               input logic [out_w-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic read_row();
        @(posedge clk);
        #2;
        channel_out_en = 1'b1;
        @(negedge clk);
        captured[exp_row] = out;
        check_value($sformatf("out row %0d", exp_row), expected_row(exp_row), out);
        exp_row = (exp_row + 1) % rows;
    endtask

    task automatic idle_readout(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            channel_out_en = 1'b0;
            @(negedge clk);
            check_value("out while idle", '0, out);
        end
    endtask

    task automatic read_all_rows();
        repeat (rows) read_row();
        idle_readout(1);
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic test_reset_zeros();
        apply_reset(mode_88);
        idle_readout(3);
        read_all_rows();
    endtask

    task automatic test_mode88_known();
        apply_reset(mode_88);
        // weights 1, 5, -3, -128 for rows 0..3
        drive_beat({8'h80, 8'hFD, 8'h05, 8'h01}, {16'hFF01, 16'h8040, 16'h0203, 16'h10FF});
        finish_beats();
        read_all_rows();
        // -128 x 255 and -128 x 16 in row 3, column 0
        check_value("out row 3 col 0", out_w'(48'hFFF800_FF8080), out_w'(captured[3][47:0]));
    endtask

    task automatic test_mode88_random();
        apply_reset(mode_88);
        for (int b = 0; b < 10; b++) begin
            // every other beat forces negative weights in rows 1 and 3
            drive_beat((b % 2) ? ($urandom | 32'h8000_8000) : $urandom, {$urandom, $urandom});
        end
        finish_beats();
        read_all_rows();
    endtask

    task automatic test_mode18_random();
        apply_reset(mode_18);
        repeat (10) drive_beat($urandom, {$urandom, $urandom});
        finish_beats();
        read_all_rows();
    endtask

    task automatic test_readout_control();
        apply_reset(mode_88);
        // distinct weights keep every row distinguishable
        drive_beat({8'h04, 8'h03, 8'h02, 8'h01}, {$urandom, $urandom} | 64'h0101_0101_0101_0101);
        finish_beats();
        repeat (2 * rows) read_row();
        read_row();
        read_row();
        idle_readout(3);
        // resumes at row 2
        read_row();
        read_row();
        idle_readout(1);
    endtask

    task automatic test_beat_gaps();
        apply_reset(mode_18);
        for (int b = 0; b < 12; b++) begin
            if ($urandom % 2) begin
                drive_beat($urandom, {$urandom, $urandom});
            end else begin
                skip_beat();
            end
        end
        finish_beats();
        read_all_rows();
    endtask

    initial begin
        clk_init_done: begin
            channel_out_reset = 1'b1;
            en                = 1'b0;
            mode              = mode_88;
            row_in            = '0;
            column_in         = '0;
            channel_out_en    = 1'b0;
            errors            = 0;
            checks            = 0;
            exp_row           = 0;
        end
        void'($urandom(32'ha1cc_f5bd));

        test_reset_zeros();
        test_mode88_known();
        test_mode88_random();
        test_mode18_random();
        test_readout_control();
        test_beat_gaps();

        errors = errors + dut0.u_readout.u_assert.fail_count;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/sa_tb_assertions.sv ====
`timescale 1ns/10ps

module sa_tb_assertions #(
    parameter int rows  = 4,
    parameter int cols  = 4,
    parameter int cnt_w = 2
) (
    input logic                               clk,
    input logic                               channel_out_reset,
    input logic                               channel_out_en,
    input logic [cnt_w-1:0]                   row_cnt,
    input logic [cols*sa_pkg::pe_out_w-1:0]   out
);
    // assertion failures seen so far
    int fail_count = 0;

    // bus gated off between reads
    out_zero_when_idle: assert property (@(posedge clk) !channel_out_en |-> out == '0)
        else begin
            fail_count++;
            $error("out is not zero while channel_out_en is low");
        end

    // each enabled read moves to the next row, wrapping below rows
    counter_in_range: assert property (
        @(posedge clk) disable iff (channel_out_reset)
        channel_out_en |=> int'(row_cnt) == (int'($past(row_cnt)) + 1) % rows
    ) else begin
        fail_count++;
        $error("row counter did not step to the next row below the array row count");
    end

    // counter restarts from row 0
    counter_cleared: assert property (@(posedge clk) channel_out_reset |=> row_cnt == '0)
        else begin
            fail_count++;
            $error("row counter not zero one cycle after reset");
        end

endmodule

// ==== verilog.f ====
rtl/sa_pkg.sv
rtl/sa_operand_if.sv
rtl/sa_operand_skew.sv
rtl/sa_pe.sv
rtl/sa_pe_array.sv
rtl/sa_row_readout.sv
rtl/sa_top.sv
testbench/sa_tb_assertions.sv
testbench/sa_tb.sv
